// File: Makefile
TOP := tb_fe_frontend
LOG := sim.log

.PHONY: all sim lint clean

all: sim

# build, run, then decide pass or fail from the log
sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module fe_frontend

clean:
	rm -rf obj_dir $(LOG)

// File: fe_credit_counter.sv
// counts slots reserved at request time, freed when the back-end pops
// drop clears everything and wins over reserve and release
`timescale 1ns/1ps

module fe_credit_counter (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        reserve_i,
    input  logic                        release_i,
    input  logic                        drop_i,
    output logic [fe_pkg::FE_CNT_W-1:0] count_o
);

    logic [fe_pkg::FE_CNT_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (drop_i) begin
            count_q <= '0;
        end else if (reserve_i && !release_i) begin
            count_q <= count_q + 1'b1;
        end else if (release_i && !reserve_i) begin
            count_q <= count_q - 1'b1;
        end
        // reserve together with release leaves the count unchanged
    end

    assign count_o = count_q;

endmodule

// File: fe_fetch_fsm.sv
// redirect inputs are expected as single-cycle pulses and are ignored in ST_BOOT
// assumes the memory answers every request exactly one cycle later
`timescale 1ns/1ps

module fe_fetch_fsm (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          rsp_valid_i,
    input  logic                          taken_i,
    input  logic                          pop_i,
    input  fe_pkg::resolve_t              resolve_i,
    input  logic                          eret_i,
    input  logic                          ex_valid_i,
    input  logic [fe_pkg::FE_CNT_W-1:0]   count_i,
    output fe_pkg::pc_sel_e               pc_sel_o,
    output logic                          req_o,
    output logic                          push_o,
    output logic                          flush_o
);

    fe_pkg::fetch_state_e state_d;
    fe_pkg::fetch_state_e state_q;
    logic                 mispredict;
    logic                 ext_redirect;
    logic                 predict;
    logic                 can_req;

    // ------------------------------------------------------------------------
    // redirect sources
    // ------------------------------------------------------------------------
    assign mispredict   = resolve_i.valid & resolve_i.mispredict;
    assign ext_redirect = ex_valid_i | eret_i | mispredict;
    // a taken prediction only counts for a response that is kept
    assign predict      = rsp_valid_i & taken_i & ~ext_redirect;
    assign can_req      = count_i < fe_pkg::FE_CNT_FULL;

    // external redirect drops the response in flight
    assign push_o  = rsp_valid_i & ~ext_redirect;
    assign flush_o = ext_redirect;

    always_comb begin
        pc_sel_o = fe_pkg::PC_HOLD;
        req_o    = 1'b0;
        state_d  = state_q;
        unique case (state_q)
            fe_pkg::ST_BOOT: begin
                // load the boot address, first request comes next cycle
                pc_sel_o = fe_pkg::PC_BOOT;
                state_d  = fe_pkg::ST_RUN;
            end
            fe_pkg::ST_RUN, fe_pkg::ST_NO_CREDIT: begin
                // priority: exception, return, mispredict, prediction, sequential
                if (ex_valid_i) begin
                    pc_sel_o = fe_pkg::PC_TRAP;
                end else if (eret_i) begin
                    pc_sel_o = fe_pkg::PC_ERET;
                end else if (mispredict) begin
                    pc_sel_o = fe_pkg::PC_MISPREDICT;
                end else if (predict) begin
                    pc_sel_o = fe_pkg::PC_PREDICT;
                end else if (state_q == fe_pkg::ST_RUN && can_req) begin
                    req_o    = 1'b1;
                    pc_sel_o = fe_pkg::PC_SEQ;
                end
                // credits all taken and none freed this cycle, so park
                if (ext_redirect) begin
                    state_d = fe_pkg::ST_RUN;
                end else if (!can_req && !pop_i) begin
                    state_d = fe_pkg::ST_NO_CREDIT;
                end else begin
                    state_d = fe_pkg::ST_RUN;
                end
            end
            default: begin
                state_d = fe_pkg::ST_BOOT;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= fe_pkg::ST_BOOT;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: fe_frontend.sv
// one 32-bit instruction per request, memory latency fixed at one cycle
// imem_rsp_i must follow each accepted request exactly once, no back-pressure
`timescale 1ns/1ps

module fe_frontend (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic [rv_isa_pkg::XLEN-1:0] boot_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] epc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] trap_vector_base_i,
    input  fe_pkg::resolve_t            resolve_i,
    input  logic                        eret_i,
    input  logic                        ex_valid_i,
    output fe_pkg::imem_req_t           imem_req_o,
    input  fe_pkg::imem_rsp_t           imem_rsp_i,
    output fe_pkg::fetch_entry_t        fetch_entry_o,
    output logic                        fetch_entry_valid_o,
    input  logic                        fetch_entry_ready_i
);

    fe_pkg::pc_sel_e             pc_sel;
    fe_pkg::scan_t               scan;
    fe_pkg::fetch_entry_t        entry;
    logic [rv_isa_pkg::XLEN-1:0] fetch_addr;
    logic [rv_isa_pkg::XLEN-1:0] rsp_addr;
    logic [fe_pkg::FE_CNT_W-1:0] credit_cnt;
    logic                        req;
    logic                        push;
    logic                        pop;
    logic                        flush;

    // ------------------------------------------------------------------------
    // memory request
    // ------------------------------------------------------------------------
    assign imem_req_o.req  = req;
    assign imem_req_o.addr = fetch_addr;

    fe_pc_gen i_pc_gen (
        .clk_i               ( clk_i              ),
        .rst_ni              ( rst_ni             ),
        .pc_sel_i            ( pc_sel             ),
        .boot_addr_i         ( boot_addr_i        ),
        .predict_target_i    ( scan.target        ),
        .epc_i               ( epc_i              ),
        .trap_vector_base_i  ( trap_vector_base_i ),
        .mispredict_target_i ( resolve_i.target   ),
        .req_i               ( req                ),
        .fetch_addr_o        ( fetch_addr         ),
        .rsp_addr_o          ( rsp_addr           )
    );

    // pre-decode straight off the memory response
    fe_instr_scan i_instr_scan (
        .instr_i ( imem_rsp_i.data ),
        .addr_i  ( rsp_addr        ),
        .scan_o  ( scan            )
    );

    fe_fetch_fsm i_fetch_fsm (
        .clk_i       ( clk_i            ),
        .rst_ni      ( rst_ni           ),
        .rsp_valid_i ( imem_rsp_i.valid ),
        .taken_i     ( scan.taken       ),
        .pop_i       ( pop              ),
        .resolve_i   ( resolve_i        ),
        .eret_i      ( eret_i           ),
        .ex_valid_i  ( ex_valid_i       ),
        .count_i     ( credit_cnt       ),
        .pc_sel_o    ( pc_sel           ),
        .req_o       ( req              ),
        .push_o      ( push             ),
        .flush_o     ( flush            )
    );

    fe_credit_counter i_credit_counter (
        .clk_i     ( clk_i      ),
        .rst_ni    ( rst_ni     ),
        .reserve_i ( req        ),
        .release_i ( pop        ),
        .drop_i    ( flush      ),
        .count_o   ( credit_cnt )
    );

    // ------------------------------------------------------------------------
    // entry towards the back-end
    // ------------------------------------------------------------------------
    assign entry.addr   = rsp_addr;
    assign entry.instr  = imem_rsp_i.data;
    assign entry.cf     = scan.cf;
    assign entry.taken  = scan.taken;
    assign entry.target = scan.target;

    fe_instr_queue i_instr_queue (
        .clk_i   ( clk_i               ),
        .rst_ni  ( rst_ni              ),
        .flush_i ( flush               ),
        .push_i  ( push                ),
        .entry_i ( entry               ),
        .entry_o ( fetch_entry_o       ),
        .valid_o ( fetch_entry_valid_o ),
        .ready_i ( fetch_entry_ready_i ),
        .pop_o   ( pop                 )
    );

endmodule

// File: fe_instr_queue.sv
// no full flag: the credit counter keeps pushes within FE_QUEUE_DEPTH
// depth must be a power of two so the pointers wrap naturally
`timescale 1ns/1ps

module fe_instr_queue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 flush_i,
    input  logic                 push_i,
    input  fe_pkg::fetch_entry_t entry_i,
    output fe_pkg::fetch_entry_t entry_o,
    output logic                 valid_o,
    input  logic                 ready_i,
    output logic                 pop_o
);

    fe_pkg::fetch_entry_t        mem_q [fe_pkg::FE_QUEUE_DEPTH];
    // msb is the wrap bit, low bits index the storage
    logic [fe_pkg::FE_CNT_W-1:0] wr_ptr_q;
    logic [fe_pkg::FE_CNT_W-1:0] rd_ptr_q;

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    assign valid_o = wr_ptr_q != rd_ptr_q;
    assign pop_o   = valid_o & ready_i;
    assign entry_o = mem_q[rd_ptr_q[fe_pkg::FE_IDX_W-1:0]];

    // ------------------------------------------------------------------------
    // storage and pointers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q[fe_pkg::FE_IDX_W-1:0]] <= entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            // redirect, everything stored is on the wrong path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

// File: fe_instr_scan.sv
// purely combinational and recognises only JAL and conditional branches
// JALR and all other opcodes report CF_NONE with target equal to addr_i
`timescale 1ns/1ps

module fe_instr_scan (
    input  logic [rv_isa_pkg::ILEN-1:0] instr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] addr_i,
    output fe_pkg::scan_t               scan_o
);

    rv_isa_pkg::opcode_e         opcode;
    logic [rv_isa_pkg::XLEN-1:0] b_imm;
    logic [rv_isa_pkg::XLEN-1:0] j_imm;
    logic [rv_isa_pkg::XLEN-1:0] imm;
    logic                        sign;

    assign opcode = rv_isa_pkg::opcode_e'(instr_i[rv_isa_pkg::OPCODE_W-1:0]);
    assign sign   = instr_i[rv_isa_pkg::IMM_SIGN_BIT];

    // B-type 13-bit offset with bit 0 always zero
    assign b_imm = {{20{sign}}, instr_i[rv_isa_pkg::B_IMM11_BIT], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    // J-type 21-bit offset with bit 0 always zero
    assign j_imm = {{12{sign}}, instr_i[19:12], instr_i[rv_isa_pkg::J_IMM11_BIT],
                    instr_i[30:21], 1'b0};

    always_comb begin
        scan_o.cf    = fe_pkg::CF_NONE;
        scan_o.taken = 1'b0;
        imm          = '0;
        unique case (opcode)
            rv_isa_pkg::OPC_JAL: begin
                // direct jump that is always followed
                scan_o.cf    = fe_pkg::CF_JUMP;
                scan_o.taken = 1'b1;
                imm          = j_imm;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // static rule takes backward branches and not forward ones
                scan_o.cf    = fe_pkg::CF_BRANCH;
                scan_o.taken = b_imm[rv_isa_pkg::XLEN-1];
                imm          = b_imm;
            end
            default: begin
                imm = '0;
            end
        endcase
        // pc-relative target
        scan_o.target = addr_i + imm;
    end

endmodule

// File: fe_pc_gen.sv
// next-PC comes out of reset as zero, ST_BOOT loads boot_addr_i one cycle later
// rsp_addr_o is valid for the response that follows a request by one cycle
`timescale 1ns/1ps

module fe_pc_gen (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  fe_pkg::pc_sel_e             pc_sel_i,
    input  logic [rv_isa_pkg::XLEN-1:0] boot_addr_i,
    input  logic [rv_isa_pkg::XLEN-1:0] predict_target_i,
    input  logic [rv_isa_pkg::XLEN-1:0] epc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] trap_vector_base_i,
    input  logic [rv_isa_pkg::XLEN-1:0] mispredict_target_i,
    input  logic                        req_i,
    output logic [rv_isa_pkg::XLEN-1:0] fetch_addr_o,
    output logic [rv_isa_pkg::XLEN-1:0] rsp_addr_o
);

    logic [rv_isa_pkg::XLEN-1:0] npc_d;
    logic [rv_isa_pkg::XLEN-1:0] npc_q;
    logic [rv_isa_pkg::XLEN-1:0] rsp_addr_q;

    // ------------------------------------------------------------------------
    // next-PC select
    // ------------------------------------------------------------------------
    always_comb begin
        unique case (pc_sel_i)
            fe_pkg::PC_BOOT:       npc_d = boot_addr_i;
            fe_pkg::PC_SEQ:        npc_d = npc_q + rv_isa_pkg::INSTR_BYTES;
            fe_pkg::PC_PREDICT:    npc_d = predict_target_i;
            fe_pkg::PC_MISPREDICT: npc_d = mispredict_target_i;
            fe_pkg::PC_ERET:       npc_d = epc_i;
            fe_pkg::PC_TRAP:       npc_d = trap_vector_base_i;
            default:               npc_d = npc_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q <= '0;
        end else begin
            npc_q <= npc_d;
        end
    end

    // remember the address in flight so the response can be tagged
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rsp_addr_q <= npc_q;
        end
    end

    assign fetch_addr_o = npc_q;
    assign rsp_addr_o   = rsp_addr_q;

endmodule

// File: fe_pkg.sv
// frontend types for a single-issue fetch path with a 4-entry queue
// widths derive from rv_isa_pkg, the credit count holds 0..depth inclusive
package fe_pkg;

    // ------------------------------------------------------------------------
    // queue and credit sizing
    // ------------------------------------------------------------------------
    localparam int unsigned FE_QUEUE_DEPTH = 4;
    localparam int unsigned FE_IDX_W       = $clog2(FE_QUEUE_DEPTH);
    // one extra bit so that a full count (and a wrapped pointer) fits
    localparam int unsigned FE_CNT_W       = FE_IDX_W + 1;
    localparam logic [FE_CNT_W-1:0] FE_CNT_FULL = FE_CNT_W'(FE_QUEUE_DEPTH);

    // ------------------------------------------------------------------------
    // enums
    // ------------------------------------------------------------------------
    // control flow kind found by the pre-decode
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_BRANCH = 2'd1,
        CF_JUMP   = 2'd2
    } cf_e;

    // next-PC source, priority is resolved in the FSM and not here
    typedef enum logic [2:0] {
        PC_BOOT       = 3'd0,
        PC_HOLD       = 3'd1,
        PC_SEQ        = 3'd2,
        PC_PREDICT    = 3'd3,
        PC_MISPREDICT = 3'd4,
        PC_ERET       = 3'd5,
        PC_TRAP       = 3'd6
    } pc_sel_e;

    typedef enum logic [1:0] {
        ST_BOOT      = 2'd0,
        ST_RUN       = 2'd1,
        ST_NO_CREDIT = 2'd2
    } fetch_state_e;

    // ------------------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                        req;
        logic [rv_isa_pkg::XLEN-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic                        valid;
        logic [rv_isa_pkg::ILEN-1:0] data;
    } imem_rsp_t;

    // branch resolution from the back-end
    typedef struct packed {
        logic                        valid;
        logic                        mispredict;
        logic [rv_isa_pkg::XLEN-1:0] target;
    } resolve_t;

    typedef struct packed {
        cf_e                         cf;
        logic                        taken;
        logic [rv_isa_pkg::XLEN-1:0] target;
    } scan_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] addr;
        logic [rv_isa_pkg::ILEN-1:0] instr;
        cf_e                         cf;
        logic                        taken;
        logic [rv_isa_pkg::XLEN-1:0] target;
    } fetch_entry_t;

endpackage

// File: rv_isa_pkg.sv
// RV32I base encodings only; compressed (16-bit) instructions are not described
// fields below follow the unprivileged spec layout of a 32-bit word
package rv_isa_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN = 32;
    localparam int unsigned ILEN = 32;

    // every instruction is one word, so the sequential step is constant
    localparam logic [XLEN-1:0] INSTR_BYTES = XLEN'(ILEN / 8);

    // ------------------------------------------------------------------------
    // field positions
    // ------------------------------------------------------------------------
    // major opcode sits in the low bits of the word
    localparam int unsigned OPCODE_W = 7;

    // sign bit of every immediate format
    localparam int unsigned IMM_SIGN_BIT = 31;

    // B-type immediate pieces: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    localparam int unsigned B_IMM11_BIT = 7;
    // J-type immediate pieces: imm[20|10:1|11|19:12] in 31:12
    localparam int unsigned J_IMM11_BIT = 20;

    // ------------------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

endpackage

// File: src.f
rv_isa_pkg.sv
fe_pkg.sv
fe_instr_scan.sv
fe_pc_gen.sv
fe_fetch_fsm.sv
fe_credit_counter.sv
fe_instr_queue.sv
fe_frontend.sv
tb_fe_frontend.sv

// File: tb_fe_frontend.sv
// self-checking testbench with a one-cycle memory model and random back-end ready
// redirects are pulsed while ready is low so the next accepted entry is unambiguous
`timescale 1ns/1ps

module tb_fe_frontend;

    // ------------------------------------------------------------------------
    // test constants
    // ------------------------------------------------------------------------
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;

    // program layout around the boot address
    localparam logic [31:0] BOOT_ADDR    = 32'h0000_1000;
    localparam logic [31:0] FWD_BR_ADDR  = BOOT_ADDR + 32'h08;
    localparam logic [31:0] LOOP_ADDR    = BOOT_ADDR + 32'h0c;
    localparam logic [31:0] BACK_BR_ADDR = BOOT_ADDR + 32'h14;
    localparam logic [31:0] JAL_ADDR     = BOOT_ADDR + 32'h18;
    localparam logic [31:0] JALR_ADDR    = BOOT_ADDR + 32'h28;
    localparam logic [31:0] ERET_AT      = BOOT_ADDR + 32'h40;
    localparam logic [31:0] EPC_ADDR     = 32'h0000_1100;
    localparam logic [31:0] TRAP_ADDR    = 32'h0000_2000;
    // mispredict target that loses against the exception
    localparam logic [31:0] STRAY_TARGET = 32'h0000_3000;

    localparam int LOOP_CNT = 3;
    localparam int TAIL_CNT = 16;
    // boot run with loop passes, jal/jalr stretch, epc stretch, trap stretch, tail
    localparam int ENTRY_CNT = 3 + 3 * LOOP_CNT + 8 + 5 + 5 + TAIL_CNT;

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------
    logic                 clk_i       = 1'b0;
    logic                 rst_ni      = 1'b0;
    logic [31:0]          boot_addr   = BOOT_ADDR;
    logic [31:0]          epc         = EPC_ADDR;
    logic [31:0]          trap_base   = TRAP_ADDR;
    fe_pkg::resolve_t     resolve     = '0;
    logic                 eret        = 1'b0;
    logic                 ex_valid    = 1'b0;
    fe_pkg::imem_req_t    imem_req;
    fe_pkg::imem_rsp_t    imem_rsp    = '0;
    fe_pkg::fetch_entry_t fetch_entry;
    logic                 fetch_valid;
    logic                 fetch_ready = 1'b0;

    // checker state
    logic [31:0] expect_addr = BOOT_ADDR;
    logic [15:0] lfsr        = 16'd55;
    int          phase       = 0;
    int          loop_visits = 0;
    int          tail        = 0;
    int          accepted    = 0;
    int          in_flight   = 0;
    logic        done        = 1'b0;

    fe_frontend i_fe_frontend (
        .clk_i               ( clk_i       ),
        .rst_ni              ( rst_ni      ),
        .boot_addr_i         ( boot_addr   ),
        .epc_i               ( epc         ),
        .trap_vector_base_i  ( trap_base   ),
        .resolve_i           ( resolve     ),
        .eret_i              ( eret        ),
        .ex_valid_i          ( ex_valid    ),
        .imem_req_o          ( imem_req    ),
        .imem_rsp_i          ( imem_rsp    ),
        .fetch_entry_o       ( fetch_entry ),
        .fetch_entry_valid_o ( fetch_valid ),
        .fetch_entry_ready_i ( fetch_ready )
    );

    // ------------------------------------------------------------------------
    // instruction encoders and program image
    // ------------------------------------------------------------------------
    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rv_isa_pkg::OPC_JALR};
    endfunction

    // off is the byte offset whose bit 0 the format drops
    function automatic logic [31:0] branch_word(input logic [2:0] funct3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11],
                rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        logic [31:0] word;
        logic [11:0] fill;
        // filler ADDI immediate folds in every address bit
        fill = addr[13:2] ^ addr[25:14] ^ {4'd0, addr[31:26], addr[1:0]};
        case (addr)
            // forward beq that is predicted not taken
            FWD_BR_ADDR:  word = branch_word(3'b000, 5'd1, 5'd2, 13'h00c);
            // bne back to the loop head and predicted taken
            BACK_BR_ADDR: word = branch_word(3'b001, 5'd1, 5'd0, 13'(LOOP_ADDR - BACK_BR_ADDR));
            JAL_ADDR:     word = jal_word(5'd0, 21'(JALR_ADDR - JAL_ADDR));
            JALR_ADDR:    word = jalr_word(5'd0, 5'd1, 12'd0);
            default:      word = addi_word(5'd1, 5'd1, fill);
        endcase
        return word;
    endfunction

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    // JAL is always taken and a branch only with a negative offset
    // anything else falls through to the next word
    function automatic fe_pkg::scan_t predecode_ref(input logic [31:0] addr,
                                                    input logic [31:0] word);
        fe_pkg::scan_t s;
        logic [31:0]   off;
        s.cf     = fe_pkg::CF_NONE;
        s.taken  = 1'b0;
        s.target = addr;
        if (word[6:0] == rv_isa_pkg::OPC_JAL) begin
            off      = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            s.cf     = fe_pkg::CF_JUMP;
            s.taken  = 1'b1;
            s.target = addr + off;
        end else if (word[6:0] == rv_isa_pkg::OPC_BRANCH) begin
            off      = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            s.cf     = fe_pkg::CF_BRANCH;
            s.taken  = off[31];
            s.target = addr + off;
        end
        return s;
    endfunction

    function automatic logic [31:0] next_addr_ref(input logic [31:0] addr,
                                                  input logic [31:0] word);
        fe_pkg::scan_t s;
        s = predecode_ref(addr, word);
        return s.taken ? s.target : addr + 32'd4;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_on_error($sformatf("FAILED at %0t: %s expected 0x%08h, got 0x%08h",
                                $time, name, exp, act));
    endtask

    // ------------------------------------------------------------------------
    // clock, reset and watchdog
    // ------------------------------------------------------------------------
    initial begin
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        wait (done);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + ENTRY_CNT * 40) @(posedge clk_i);
        stop_on_error($sformatf("watchdog timeout: only %0d of %0d entries were accepted",
                                accepted, ENTRY_CNT));
    end

    // memory answers every cycle and flags valid only for a request one cycle back
    always @(posedge clk_i) begin
        imem_rsp.valid <= imem_req.req;
        imem_rsp.data  <= program_word(imem_req.addr);
    end

    // ------------------------------------------------------------------------
    // back-end model and compare
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin : compare_proc
        fe_pkg::fetch_entry_t ent;
        fe_pkg::scan_t        exp_scan;
        fe_pkg::resolve_t     res;
        logic                 ext;
        if (rst_ni && !done) begin
            // pulses last a single cycle
            resolve  <= '0;
            eret     <= 1'b0;
            ex_valid <= 1'b0;
            lfsr = lfsr_step(lfsr);
            fetch_ready <= lfsr[0];

            // requests minus accepted entries since the last external redirect
            ext = ex_valid | eret | (resolve.valid & resolve.mispredict);
            if (ext) begin
                in_flight = 0;
            end else begin
                if (imem_req.req) begin
                    in_flight++;
                end
                if (fetch_valid && fetch_ready) begin
                    in_flight--;
                end
            end
            assert (in_flight <= int'(fe_pkg::FE_QUEUE_DEPTH))
                else stop_on_error($sformatf("more requests in flight than queue slots: %0d",
                                             in_flight));

            if (fetch_valid && fetch_ready) begin
                ent      = fetch_entry;
                exp_scan = predecode_ref(ent.addr, ent.instr);
                accepted++;
                assert (ent.addr == expect_addr)
                    else report_mismatch("fetch_entry_o.addr", expect_addr, ent.addr);
                assert (ent.instr == program_word(ent.addr))
                    else report_mismatch("fetch_entry_o.instr", program_word(ent.addr),
                                         ent.instr);
                assert (ent.cf == exp_scan.cf)
                    else report_mismatch("fetch_entry_o.cf", 32'(exp_scan.cf), 32'(ent.cf));
                assert (ent.taken == exp_scan.taken)
                    else report_mismatch("fetch_entry_o.taken", 32'(exp_scan.taken),
                                         32'(ent.taken));
                assert (ent.target == exp_scan.target)
                    else report_mismatch("fetch_entry_o.target", exp_scan.target, ent.target);
                expect_addr = next_addr_ref(ent.addr, ent.instr);

                // each redirect holds ready low for its pulse cycle
                res = '0;
                case (phase)
                    0: begin
                        if (ent.addr == BACK_BR_ADDR) begin
                            loop_visits++;
                        end
                        // on loop exit the backward branch resolves not taken
                        if (loop_visits == LOOP_CNT) begin
                            res.valid      = 1'b1;
                            res.mispredict = 1'b1;
                            res.target     = BACK_BR_ADDR + 32'd4;
                            resolve       <= res;
                            fetch_ready   <= 1'b0;
                            expect_addr    = res.target;
                            phase          = 1;
                        end
                    end
                    1: begin
                        if (ent.addr == ERET_AT) begin
                            eret        <= 1'b1;
                            fetch_ready <= 1'b0;
                            expect_addr  = EPC_ADDR;
                            phase        = 2;
                        end
                    end
                    2: begin
                        if (ent.addr == EPC_ADDR + 32'h10) begin
                            ex_valid    <= 1'b1;
                            fetch_ready <= 1'b0;
                            expect_addr  = TRAP_ADDR;
                            phase        = 3;
                        end
                    end
                    3: begin
                        // with all three at once the exception must win
                        if (ent.addr == TRAP_ADDR + 32'h10) begin
                            res.valid      = 1'b1;
                            res.mispredict = 1'b1;
                            res.target     = STRAY_TARGET;
                            resolve       <= res;
                            eret          <= 1'b1;
                            ex_valid      <= 1'b1;
                            fetch_ready   <= 1'b0;
                            expect_addr    = TRAP_ADDR;
                            phase          = 4;
                        end
                    end
                    default: begin
                        tail++;
                        if (tail == TAIL_CNT) begin
                            done <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule
